// ==== hw/divPkg.sv ====
package divPkg;

	// ####################
	// Opcodes
	// ####################

	// Low bit selects the remainder, high bit selects signed operation
	typedef enum logic [1:0]
	{
		DivU = 2'b00,
		RemU = 2'b01,
		Div  = 2'b10,
		Rem  = 2'b11
	} divOpE;

	// ####################
	// Pipeline control
	// ####################

	// Travels with one division from the operand stage to the result stage
	typedef struct packed
	{
		divOpE op;
		logic  negQuot; // Quotient magnitude must be negated
		logic  negRem;  // Remainder magnitude must be negated
		logic  divZero; // Divisor was zero
	} divCtrlS;

endpackage

// ==== hw/divOperandStage.sv ====
`timescale 1ns/1ps

module divOperandStage
#(
	parameter int Width = 8
)
(
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 ReqValid,
	input  divPkg::divOpE        ReqOp,
	input  logic [Width-1:0]     Dividend,
	input  logic [Width-1:0]     Divisor,
	input  logic                 CoreBusy,
	output logic                 Start,
	output logic [Width-1:0]     MagA,
	output logic [Width-1:0]     MagB,
	output divPkg::divCtrlS      Ctrl,
	output logic                 Pending
);

	logic accept;
	logic signedOp;
	logic signA;
	logic signB;
	logic divZero;
	logic startQ;

	// A request is taken only when nothing is in flight
	assign accept = ReqValid && !startQ && !CoreBusy;

	assign signedOp = (ReqOp == divPkg::Div) || (ReqOp == divPkg::Rem);
	assign signA    = signedOp && Dividend[Width-1];
	assign signB    = signedOp && Divisor[Width-1];
	assign divZero  = (Divisor == '0);

	// ####################
	// Strobe
	// ####################

	always_ff @(posedge Clock or negedge Resetn)
	begin
		if (!Resetn)
			startQ <= 1'b0;
		else
			startQ <= accept; // One cycle after acceptance
	end

	assign Start   = startQ;
	assign Pending = startQ; // Covers the gap before the core raises its own Busy

	// ####################
	// Operands
	// ####################

	always_ff @(posedge Clock)
	begin
		if (accept)
		begin
			MagA         <= signA ? -Dividend : Dividend;
			MagB         <= signB ? -Divisor : Divisor;
			Ctrl.op      <= ReqOp;
			Ctrl.negQuot <= (signA ^ signB) && !divZero;
			Ctrl.negRem  <= signA;
			Ctrl.divZero <= divZero;
		end
	end

	// The core must have returned to idle whenever a new division starts
	startWhileCoreBusy: assert property (
		@(posedge Clock) disable iff (!Resetn)
		Start |-> !CoreBusy
	);

endmodule

// ==== hw/divCore.sv ====
`timescale 1ns/1ps

module divCore
#(
	parameter int Width = 8
)
(
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 Start,
	input  logic [Width-1:0]     MagA,
	input  logic [Width-1:0]     MagB,
	input  divPkg::divCtrlS      CtrlIn,
	output logic                 Busy,
	output logic                 Done,
	output logic [Width-1:0]     Quotient,
	output logic [Width-1:0]     Remainder,
	output divPkg::divCtrlS      CtrlOut
);

	localparam int CountW = (Width > 2) ? $clog2(Width) : 1;

	typedef enum logic [1:0]
	{
		Idle,
		Run,
		Finish
	} stateE;

	stateE             state;
	stateE             stateNext;
	logic [CountW-1:0] countQ;
	logic              lastStep;
	logic              doneDly;

	logic [Width-1:0]  quotQ;
	logic [Width-1:0]  remQ;
	logic [Width-1:0]  divisorQ;
	divPkg::divCtrlS   ctrlQ;

	logic [Width:0]    shifted;
	logic [Width+1:0]  diff;
	logic              carry;

	// ####################
	// Control
	// ####################

	assign lastStep = (countQ == '0);

	always_comb
	begin
		stateNext = state;
		case (state)
			Idle:
				if (Start)
					stateNext = Run;
			Run:
				if (lastStep)
					stateNext = Finish;
			Finish:
				stateNext = Idle;
			default:
				stateNext = Idle;
		endcase
	end

	always_ff @(posedge Clock or negedge Resetn)
	begin
		if (!Resetn)
		begin
			state   <= Idle;
			countQ  <= '0;
			doneDly <= 1'b0;
		end
		else
		begin
			state   <= stateNext;
			doneDly <= Done;
			if (state == Idle && Start)
				countQ <= CountW'(Width - 1);
			else if (state == Run && !lastStep)
				countQ <= countQ - 1'b1;
		end
	end

	assign Done = (state == Finish);

	// Busy stays up through the cycle in which the result stage presents its word
	assign Busy = (state != Idle) || doneDly;

	// ####################
	// Datapath
	// ####################

	// Next dividend bit enters the partial remainder from the quotient register
	assign shifted = {remQ, quotQ[Width-1]};
	assign diff    = {1'b0, shifted} + {1'b0, ~{1'b0, divisorQ}} + 1'b1;
	assign carry   = diff[Width+1]; // Set when the divisor fits

	always_ff @(posedge Clock)
	begin
		if (state == Idle && Start)
		begin
			quotQ    <= MagA;
			remQ     <= '0;
			divisorQ <= MagB;
			ctrlQ    <= CtrlIn;
		end
		else if (state == Run)
		begin
			quotQ <= {quotQ[Width-2:0], carry};
			remQ  <= carry ? diff[Width-1:0] : shifted[Width-1:0];
		end
	end

	assign Quotient  = quotQ;
	assign Remainder = remQ;
	assign CtrlOut   = ctrlQ;

	startWhileBusy: assert property (
		@(posedge Clock) disable iff (!Resetn)
		Start |-> !Busy
	);

	// One load cycle and Width iterations, then Done for a single cycle
	doneTiming: assert property (
		@(posedge Clock) disable iff (!Resetn)
		Start |-> ##(Width + 1) Done ##1 !Done
	);

endmodule

// ==== hw/divResultStage.sv ====
`timescale 1ns/1ps

module divResultStage
#(
	parameter int Width = 8
)
(
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 Done,
	input  logic [Width-1:0]     Quotient,
	input  logic [Width-1:0]     Remainder,
	input  divPkg::divCtrlS      Ctrl,
	output logic                 ResultValid,
	output logic [Width-1:0]     Result
);

	logic [Width-1:0] word;

	// ####################
	// Word selection
	// ####################

	always_comb
	begin
		case (Ctrl.op)
			divPkg::DivU:
				word = Ctrl.divZero ? '1 : Quotient;
			divPkg::RemU:
				word = Remainder;
			divPkg::Div:
				if (Ctrl.divZero)
					word = '1; // Quotient of a zero divisor is all ones
				else
					word = Ctrl.negQuot ? -Quotient : Quotient;
			divPkg::Rem:
				// Sign restore alone returns the dividend on a zero divisor
				word = Ctrl.negRem ? -Remainder : Remainder;
			default:
				word = Quotient;
		endcase
	end

	always_ff @(posedge Clock or negedge Resetn)
	begin
		if (!Resetn)
			ResultValid <= 1'b0;
		else
			ResultValid <= Done;
	end

	always_ff @(posedge Clock)
	begin
		if (Done)
			Result <= word;
	end

endmodule

// ==== hw/divUnit.sv ====
`timescale 1ns/1ps

module divUnit
#(
	parameter int Width = 8
)
(
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 ReqValid,
	input  divPkg::divOpE        ReqOp,
	input  logic [Width-1:0]     Dividend,
	input  logic [Width-1:0]     Divisor,
	output logic                 Busy,
	output logic                 ResultValid,
	output logic [Width-1:0]     Result
);

	logic             start;
	logic             pending;
	logic             coreBusy;
	logic             done;
	logic [Width-1:0] magA;
	logic [Width-1:0] magB;
	logic [Width-1:0] quotient;
	logic [Width-1:0] remainder;
	divPkg::divCtrlS  ctrlOperand;
	divPkg::divCtrlS  ctrlCore;

	divOperandStage #(.Width(Width)) operandStage
	(
		.Clock    (Clock),
		.Resetn   (Resetn),
		.ReqValid (ReqValid),
		.ReqOp    (ReqOp),
		.Dividend (Dividend),
		.Divisor  (Divisor),
		.CoreBusy (coreBusy),
		.Start    (start),
		.MagA     (magA),
		.MagB     (magB),
		.Ctrl     (ctrlOperand),
		.Pending  (pending)
	);

	divCore #(.Width(Width)) core
	(
		.Clock     (Clock),
		.Resetn    (Resetn),
		.Start     (start),
		.MagA      (magA),
		.MagB      (magB),
		.CtrlIn    (ctrlOperand),
		.Busy      (coreBusy),
		.Done      (done),
		.Quotient  (quotient),
		.Remainder (remainder),
		.CtrlOut   (ctrlCore)
	);

	divResultStage #(.Width(Width)) resultStage
	(
		.Clock       (Clock),
		.Resetn      (Resetn),
		.Done        (done),
		.Quotient    (quotient),
		.Remainder   (remainder),
		.Ctrl        (ctrlCore),
		.ResultValid (ResultValid),
		.Result      (Result)
	);

	assign Busy = pending || coreBusy; // High from acceptance through ResultValid

endmodule

// ==== tests/divUnitChecks.svh ====
// ####################
// Result checks
// ####################

resultExpected: assert property (
	@(posedge Clock) disable iff (!Resetn)
	ResultValid |-> headValid
)
else
begin
	$display("Test %s: result strobe with no accepted request in flight", testName);
	errors++;
end

resultValue: assert property (
	@(posedge Clock) disable iff (!Resetn)
	ResultValid && headValid |-> Result == headWord
)
else
begin
	$display("FAIL %s: expected %h, actual %h", testName, $sampled(headWord), $sampled(Result));
	errors++;
end

// Width+3 cycles after the accepting edge
resultOnTime: assert property (
	@(posedge Clock) disable iff (!Resetn)
	ResultValid && headValid |-> cycle == headDue
)
else
begin
	$display("FAIL %s result cycle: expected %0d, actual %0d", testName,
		$sampled(headDue), $sampled(cycle));
	errors++;
end

resultMissing: assert property (
	@(posedge Clock) disable iff (!Resetn)
	headValid && cycle == headDue |-> ResultValid
)
else
begin
	$display("Test %s: no result arrived for an accepted request", testName);
	errors++;
end

// ####################
// Busy checks
// ####################

// High from the cycle after acceptance through the result cycle, low otherwise
busyInFlight: assert property (
	@(posedge Clock) disable iff (!Resetn)
	Busy == headValid
)
else
begin
	$display("Test %s: Busy did not follow the request in flight", testName);
	errors++;
end

busyWithResult: assert property (
	@(posedge Clock) disable iff (!Resetn)
	ResultValid |-> Busy
)
else
begin
	$display("Test %s: Busy was low while a result was presented", testName);
	errors++;
end

busyReleased: assert property (
	@(posedge Clock) disable iff (!Resetn)
	ResultValid |=> !Busy
)
else
begin
	$display("Test %s: Busy stayed high after the result", testName);
	errors++;
end

idleAfterReset: assert property (
	@(posedge Clock) disable iff (!Resetn)
	!seenRequest |-> !Busy && !ResultValid
)
else
begin
	$display("Busy or ResultValid went high after reset before any request");
	errors++;
end

// ==== tests/divUnitTb.sv ====
`timescale 1ns/1ps

module divUnitTb;

	localparam int Width         = 8;
	localparam int ClockPeriod   = 40;
	localparam int UnsignedPairs = 24;
	localparam int SignedDraws   = 4; // Per sign combination
	localparam int BusyRuns      = 4;
	localparam int NumRequests   = 2 * UnsignedPairs + 8 * SignedDraws + 12 + 2 + BusyRuns;
	localparam longint WatchdogNs = 2 * NumRequests * (Width + 3) * ClockPeriod;
	localparam logic [Width-1:0] MinNeg = {1'b1, {(Width-1){1'b0}}};

	logic             Clock;
	logic             Resetn;
	logic             ReqValid;
	divPkg::divOpE    ReqOp;
	logic [Width-1:0] Dividend;
	logic [Width-1:0] Divisor;
	logic             Busy;
	logic             ResultValid;
	logic [Width-1:0] Result;

	int               seed;
	int               errors;
	int               accepted;
	int               testsRun;
	int               failedTests;
	int               testErrors;
	int               testAccepted;
	string            testName;

	// In-flight requests, front entry mirrored into the head signals for the checks
	logic [Width-1:0] expQ[$];
	int               dueQ[$];
	int               cycle;
	logic             headValid;
	logic [Width-1:0] headWord;
	int               headDue;
	logic             seenRequest;

	divUnit #(.Width(Width)) i_dut
	(
		.Clock       (Clock),
		.Resetn      (Resetn),
		.ReqValid    (ReqValid),
		.ReqOp       (ReqOp),
		.Dividend    (Dividend),
		.Divisor     (Divisor),
		.Busy        (Busy),
		.ResultValid (ResultValid),
		.Result      (Result)
	);

	initial
	begin
		Clock = 1'b0;
		forever #(ClockPeriod / 2) Clock = ~Clock;
	end

	// ####################
	// Reference model
	// ####################

	function automatic logic [Width-1:0] expectedResult(input divPkg::divOpE op,
		input logic [Width-1:0] a, input logic [Width-1:0] b);
		longint sa;
		longint sb;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		case (op)
			divPkg::DivU:
				return (b == '0) ? '1 : a / b;
			divPkg::RemU:
				return (b == '0) ? a : a % b;
			divPkg::Div:
				if (b == '0)
					return '1;
				else if (a == MinNeg && b == '1)
					return MinNeg; // Overflow wraps back to the most negative value
				else
					return Width'(sa / sb);
			default:
				if (b == '0)
					return a;
				else if (a == MinNeg && b == '1)
					return '0;
				else
					return Width'(sa % sb); // Takes the sign of the dividend
		endcase
	endfunction

	always @(posedge Clock)
	begin
		if (!Resetn)
		begin
			cycle       <= 0;
			headValid   <= 1'b0;
			headWord    <= '0;
			headDue     <= 0;
			seenRequest <= 1'b0;
		end
		else
		begin
			if (ReqValid)
				seenRequest <= 1'b1;
			if (expQ.size() > 0 && (ResultValid || dueQ[0] == cycle))
			begin
				void'(expQ.pop_front());
				void'(dueQ.pop_front());
			end
			if (ReqValid && !Busy) // Acceptance as the DUT sees it
			begin
				expQ.push_back(expectedResult(ReqOp, Dividend, Divisor));
				dueQ.push_back(cycle + Width + 3);
				accepted++;
			end
			cycle     <= cycle + 1;
			headValid <= (expQ.size() > 0);
			if (expQ.size() > 0)
			begin
				headWord <= expQ[0];
				headDue  <= dueQ[0];
			end
		end
	end

	// ####################
	// Stimulus helpers
	// ####################

	task automatic waitIdle();
		int waited;
		waited = 0;
		@(negedge Clock);
		while ((Busy || expQ.size() > 0) && waited < Width + 8)
		begin
			@(negedge Clock);
			waited++;
		end
		if (Busy || expQ.size() > 0)
		begin
			$display("Test %s: the DUT did not return to idle in time", testName);
			errors++;
		end
	endtask

	task automatic issue(input divPkg::divOpE op, input logic [Width-1:0] a,
		input logic [Width-1:0] b);
		waitIdle();
		ReqValid = 1'b1;
		ReqOp    = op;
		Dividend = a;
		Divisor  = b;
		@(negedge Clock);
		ReqValid = 1'b0;
	endtask

	// Requests offered during Busy must all be dropped
	task automatic pulseWhileBusy(input bit everyCycle);
		int pulse;
		pulse = 0;
		while (Busy && pulse < 2 * Width + 8)
		begin
			ReqValid = everyCycle || (pulse % 2 == 0);
			ReqOp    = divPkg::RemU;
			Dividend = Width'($random(seed));
			Divisor  = Width'($random(seed));
			pulse++;
			@(negedge Clock);
		end
		ReqValid = 1'b0;
	endtask

	task automatic startTest(input string name);
		testName     = name;
		testErrors   = errors;
		testAccepted = accepted;
	endtask

	task automatic finishTest();
		waitIdle();
		testsRun++;
		if (errors != testErrors)
			failedTests++;
		$display("Test %s: %0d requests accepted, %0d errors", testName,
			accepted - testAccepted, errors - testErrors);
	endtask

	initial
	begin
		logic [Width-1:0] a;
		logic [Width-1:0] b;
		logic [Width-1:0] dividends [3];
		int               i;
		seed        = 32'hd05a8142;
		errors      = 0;
		accepted    = 0;
		testsRun    = 0;
		failedTests = 0;
		testName    = "reset";
		Resetn      = 1'b0;
		ReqValid    = 1'b0;
		ReqOp       = divPkg::DivU;
		Dividend    = '0;
		Divisor     = '0;
		repeat (2) @(posedge Clock);
		@(negedge Clock);
		Resetn = 1'b1;

		startTest("resetIdle");
		repeat (4) @(negedge Clock);
		finishTest();

		startTest("unsignedRandom");
		for (i = 0; i < UnsignedPairs; i++)
		begin
			a = Width'($random(seed));
			b = Width'($random(seed)) >> (i % Width); // Small divisors too
			issue(divPkg::DivU, a, b);
			issue(divPkg::RemU, a, b);
		end
		finishTest();

		startTest("signedSigns");
		for (i = 0; i < 4 * SignedDraws; i++)
		begin
			a = Width'($random(seed)) >> 1;
			b = Width'($random(seed)) >> (1 + i % (Width - 1));
			if (a == '0)
				a = Width'(1);
			if (b == '0)
				b = Width'(1);
			if (i % 2 == 1)
				a = -a;
			if ((i / 2) % 2 == 1)
				b = -b;
			issue(divPkg::Div, a, b);
			issue(divPkg::Rem, a, b);
		end
		finishTest();

		startTest("zeroDivisor");
		dividends = '{MinNeg, ~MinNeg, Width'($random(seed))};
		for (i = 0; i < 3; i++)
		begin
			issue(divPkg::DivU, dividends[i], '0);
			issue(divPkg::RemU, dividends[i], '0);
			issue(divPkg::Div, dividends[i], '0);
			issue(divPkg::Rem, dividends[i], '0);
		end
		finishTest();

		startTest("signedOverflow");
		issue(divPkg::Div, MinNeg, '1);
		issue(divPkg::Rem, MinNeg, '1);
		finishTest();

		startTest("busyPulses");
		for (i = 0; i < BusyRuns; i++)
		begin
			issue(divPkg::Div, Width'($random(seed)), Width'($random(seed)) >> 2);
			pulseWhileBusy(i % 2 == 0);
		end
		finishTest();

		$display("Summary: %0d tests, %0d failed, %0d errors, %0d requests accepted",
			testsRun, failedTests, errors, accepted);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		#(WatchdogNs);
		$display("Watchdog expired during test %s, the run did not complete", testName);
		$display("RESULT: FAIL");
		$finish;
	end

	`include "divUnitChecks.svh"

endmodule

// ==== project.f ====
+incdir+tests
hw/divPkg.sv
hw/divOperandStage.sv
hw/divCore.sv
hw/divResultStage.sv
hw/divUnit.sv
tests/divUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the divide unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module divUnitTb -f project.f -o divUnitSim; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/divUnitSim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
	exit 0
else
	exit 1
fi
